// ==== src/rv_isa_pkg.sv ====
// RV64I integer instruction set definitions
// instruction formats, opcode and funct3 codes, and the instruction word
// decoded as R-type or I-type fields

package rv_isa_pkg;

    // register index width
    localparam int REG_W = 5;

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    // SRL and SRA, told apart by bit 30
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    typedef struct packed {
        logic [6:0]       funct7;
        logic [REG_W-1:0] rs2;
        logic [REG_W-1:0] rs1;
        logic [2:0]       funct3;
        logic [REG_W-1:0] rd;
        logic [6:0]       opcode;
    } r_fmt_t;

    // U-type immediate is imm12, rs1 and funct3 taken together
    typedef struct packed {
        logic [11:0]      imm12;
        logic [REG_W-1:0] rs1;
        logic [2:0]       funct3;
        logic [REG_W-1:0] rd;
        logic [6:0]       opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

    // addi x0, x0, 0
    localparam logic [31:0] NOP = 32'h0000_0013;

endpackage

// ==== src/rv_pipe_pkg.sv ====
// Pipeline payload definitions
// data word and the records passed between fetch, decode, execute and retire

package rv_pipe_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] word_t;

    // fetch to decode
    typedef struct packed {
        logic               valid;
        word_t              pc;
        rv_isa_pkg::instr_t instr;
    } fd_t;

    // decode to execute
    typedef struct packed {
        logic                             valid;
        word_t                            pc;
        rv_isa_pkg::opcode_e              opcode;
        logic [2:0]                       funct3;
        // instruction bit 30, selects SUB and SRA
        logic                             alt;
        logic [rv_isa_pkg::REG_W-1:0]     rd;
        logic [rv_isa_pkg::REG_W-1:0]     rs1;
        logic [rv_isa_pkg::REG_W-1:0]     rs2;
        word_t                            rs1_val;
        word_t                            rs2_val;
        word_t                            imm;
        logic                             use_imm;
        logic                             use_pc;
        logic                             illegal;
    } dx_t;

    // one retired instruction
    typedef struct packed {
        word_t                            pc;
        logic [rv_isa_pkg::REG_W-1:0]     rd;
        word_t                            value;
        logic                             we;
        logic                             illegal;
    } retire_t;

endpackage

// ==== src/rv_fetch.sv ====
// Instruction intake stage
// accepts instructions over valid/ready, tags them with the program counter
// and loads the fetch/decode register

`timescale 1ns/1ps

module rv_fetch #(
    parameter rv_pipe_pkg::word_t RESET_PC = '0
) (
    input  logic                c_clk,
    input  logic                c_rst_n,
    input  logic                instr_valid_i,
    input  rv_isa_pkg::instr_t  instr_i,
    output logic                instr_ready_o,
    input  logic                stall_i,
    output rv_pipe_pkg::fd_t    fd_o
);

    logic               accept;
    rv_pipe_pkg::word_t pc_q;
    rv_pipe_pkg::fd_t   fd_q;

    assign instr_ready_o = ~stall_i;
    assign accept        = instr_valid_i & instr_ready_o;

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            pc_q <= RESET_PC;
        end else if (accept) begin
            pc_q <= pc_q + 64'd4;
        end
    end

    // bubble when nothing arrives
    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            fd_q.valid <= 1'b0;
            fd_q.pc    <= '0;
            fd_q.instr <= rv_isa_pkg::NOP;
        end else if (!stall_i) begin
            fd_q.valid <= instr_valid_i;
            fd_q.pc    <= pc_q;
            fd_q.instr <= instr_valid_i ? instr_i : rv_isa_pkg::NOP;
        end
    end

    assign fd_o = fd_q;

    a_pc_hold: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        !accept |=> $stable(pc_q))
        else $error("pc moved without an accepted instruction");

endmodule

// ==== src/rv_regfile.sv ====
// Integer register file
// 32 x 64-bit, asynchronous reads, x0 fixed at zero, same-cycle write-through

`timescale 1ns/1ps

module rv_regfile (
    input  logic                            c_clk,
    input  logic                            c_rst_n,
    input  logic [rv_isa_pkg::REG_W-1:0]    rs1_idx_i,
    input  logic [rv_isa_pkg::REG_W-1:0]    rs2_idx_i,
    output rv_pipe_pkg::word_t              rs1_val_o,
    output rv_pipe_pkg::word_t              rs2_val_o,
    input  logic [rv_isa_pkg::REG_W-1:0]    rd_idx_i,
    input  rv_pipe_pkg::word_t              rd_val_i,
    input  logic                            rd_we_i
);

    localparam int NREGS = 1 << rv_isa_pkg::REG_W;

    rv_pipe_pkg::word_t regs_q [NREGS];

    // x0 is never written
    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (rd_we_i && (rd_idx_i != '0)) begin
            regs_q[rd_idx_i] <= rd_val_i;
        end
    end

    function automatic rv_pipe_pkg::word_t read_port(
        input logic [rv_isa_pkg::REG_W-1:0] idx
    );
        if (idx == '0) begin
            return '0;
        end
        // value being written this cycle
        if (rd_we_i && (idx == rd_idx_i)) begin
            return rd_val_i;
        end
        return regs_q[idx];
    endfunction

    assign rs1_val_o = read_port(rs1_idx_i);
    assign rs2_val_o = read_port(rs2_idx_i);

    a_x0_zero: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        regs_q[0] == '0)
        else $error("x0 entry holds a nonzero value");

endmodule

// ==== src/rv_decode.sv ====
// Decode stage
// splits the instruction by opcode, builds the immediate, reads the
// register file and loads the decode/execute register

`timescale 1ns/1ps

module rv_decode (
    input  logic                            c_clk,
    input  logic                            c_rst_n,
    input  rv_pipe_pkg::fd_t                fd_i,
    input  logic                            stall_i,
    output logic [rv_isa_pkg::REG_W-1:0]    rs1_idx_o,
    output logic [rv_isa_pkg::REG_W-1:0]    rs2_idx_o,
    input  rv_pipe_pkg::word_t              rs1_val_i,
    input  rv_pipe_pkg::word_t              rs2_val_i,
    output rv_pipe_pkg::dx_t                dx_o
);

    rv_isa_pkg::instr_t ir;
    logic               is_op_imm;
    logic               is_op;
    logic               is_lui;
    logic               is_auipc;
    logic               is_u;
    logic               is_shift;
    rv_pipe_pkg::word_t imm;
    rv_pipe_pkg::dx_t   dx_d;
    rv_pipe_pkg::dx_t   dx_q;

    assign ir        = fd_i.instr;
    assign is_op_imm = (ir.i_fmt.opcode == rv_isa_pkg::OPC_OP_IMM);
    assign is_op     = (ir.r_fmt.opcode == rv_isa_pkg::OPC_OP);
    assign is_lui    = (ir.i_fmt.opcode == rv_isa_pkg::OPC_LUI);
    assign is_auipc  = (ir.i_fmt.opcode == rv_isa_pkg::OPC_AUIPC);
    assign is_u      = is_lui | is_auipc;
    assign is_shift  = (ir.i_fmt.funct3 == rv_isa_pkg::F3_SLL) ||
                       (ir.i_fmt.funct3 == rv_isa_pkg::F3_SR);

    always_comb begin
        if (is_u) begin
            imm = {{32{ir.i_fmt.imm12[11]}}, ir.i_fmt.imm12, ir.i_fmt.rs1,
                   ir.i_fmt.funct3, 12'b0};
        end else if (is_shift) begin
            // shamt only, drops the SRAI marker bit
            imm = {58'b0, ir.i_fmt.imm12[5:0]};
        end else begin
            imm = {{52{ir.i_fmt.imm12[11]}}, ir.i_fmt.imm12};
        end
    end

    // U-type rs1 bits belong to the immediate, so read x0 instead
    assign rs1_idx_o = (is_op | is_op_imm) ? ir.i_fmt.rs1 : '0;
    assign rs2_idx_o = is_op ? ir.r_fmt.rs2 : '0;

    always_comb begin
        dx_d.valid   = fd_i.valid;
        dx_d.pc      = fd_i.pc;
        dx_d.opcode  = rv_isa_pkg::opcode_e'(ir.i_fmt.opcode);
        dx_d.funct3  = is_u ? rv_isa_pkg::F3_ADD : ir.i_fmt.funct3;
        dx_d.alt     = (is_op | is_op_imm) & ir.r_fmt.funct7[5];
        dx_d.rd      = ir.i_fmt.rd;
        dx_d.rs1     = rs1_idx_o;
        dx_d.rs2     = rs2_idx_o;
        dx_d.rs1_val = rs1_val_i;
        dx_d.rs2_val = rs2_val_i;
        dx_d.imm     = imm;
        dx_d.use_imm = ~is_op;
        dx_d.use_pc  = is_auipc;
        dx_d.illegal = ~(is_op_imm | is_op | is_u);
    end

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            dx_q <= '0;
        end else if (!stall_i) begin
            dx_q <= dx_d;
        end
    end

    assign dx_o = dx_q;

endmodule

// ==== src/rv_execute.sv ====
// Execute and writeback stage
// forwards from the writeback register, runs the 64-bit ALU, drives the
// retire port and register write, and raises the pipeline stall

`timescale 1ns/1ps

module rv_execute (
    input  logic                            c_clk,
    input  logic                            c_rst_n,
    input  rv_pipe_pkg::dx_t                dx_i,
    input  logic                            retire_ready_i,
    output logic                            retire_valid_o,
    output rv_pipe_pkg::retire_t            retire_o,
    output logic                            stall_o,
    output logic [rv_isa_pkg::REG_W-1:0]    rd_idx_o,
    output rv_pipe_pkg::word_t              rd_val_o,
    output logic                            rd_we_o
);

    logic                   fwd_ok;
    logic                   sub;
    logic [5:0]             shamt;
    rv_pipe_pkg::word_t     rs1_fwd;
    rv_pipe_pkg::word_t     rs2_fwd;
    rv_pipe_pkg::word_t     op_a;
    rv_pipe_pkg::word_t     op_b;
    rv_pipe_pkg::word_t     sra_res;
    rv_pipe_pkg::word_t     alu_res;
    logic                   wb_valid_q;
    rv_pipe_pkg::retire_t   wb_q;

    // producer one ahead sits in the writeback register
    assign fwd_ok  = wb_valid_q & wb_q.we & (wb_q.rd != '0);
    assign rs1_fwd = (fwd_ok && (wb_q.rd == dx_i.rs1)) ? wb_q.value : dx_i.rs1_val;
    assign rs2_fwd = (fwd_ok && (wb_q.rd == dx_i.rs2)) ? wb_q.value : dx_i.rs2_val;

    assign op_a  = dx_i.use_pc ? dx_i.pc : rs1_fwd;
    assign op_b  = dx_i.use_imm ? dx_i.imm : rs2_fwd;
    assign shamt = op_b[5:0];
    assign sub   = dx_i.alt && (dx_i.opcode == rv_isa_pkg::OPC_OP);

    always_comb begin
        sra_res = $signed(op_a) >>> shamt;
        case (dx_i.funct3)
            rv_isa_pkg::F3_ADD:  alu_res = sub ? (op_a - op_b) : (op_a + op_b);
            rv_isa_pkg::F3_SLL:  alu_res = op_a << shamt;
            rv_isa_pkg::F3_SLT:  alu_res = {63'b0, $signed(op_a) < $signed(op_b)};
            rv_isa_pkg::F3_SLTU: alu_res = {63'b0, op_a < op_b};
            rv_isa_pkg::F3_XOR:  alu_res = op_a ^ op_b;
            rv_isa_pkg::F3_SR:   alu_res = dx_i.alt ? sra_res : (op_a >> shamt);
            rv_isa_pkg::F3_OR:   alu_res = op_a | op_b;
            default:             alu_res = op_a & op_b;
        endcase
    end

    always_ff @(posedge c_clk or negedge c_rst_n) begin
        if (!c_rst_n) begin
            wb_valid_q <= 1'b0;
        end else if (!stall_o) begin
            wb_valid_q <= dx_i.valid;
        end
    end

    always_ff @(posedge c_clk) begin
        if (!stall_o) begin
            wb_q.pc      <= dx_i.pc;
            wb_q.rd      <= dx_i.rd;
            wb_q.value   <= dx_i.illegal ? '0 : alu_res;
            wb_q.we      <= ~dx_i.illegal;
            wb_q.illegal <= dx_i.illegal;
        end
    end

    assign retire_valid_o = wb_valid_q;
    assign retire_o       = wb_q;
    assign stall_o        = retire_valid_o & ~retire_ready_i;

    // register write only on the retire handshake
    assign rd_idx_o = wb_q.rd;
    assign rd_val_o = wb_q.value;
    assign rd_we_o  = retire_valid_o & retire_ready_i & wb_q.we;

    a_retire_hold: assert property (@(posedge c_clk) disable iff (!c_rst_n)
        (retire_valid_o && !retire_ready_i) |=> (retire_valid_o && $stable(retire_o)))
        else $error("retire record changed under back-pressure");

endmodule

// ==== src/rv_core.sv ====
// RV64I integer pipeline core
// fetch, decode, execute/writeback and the register file

`timescale 1ns/1ps

module rv_core #(
    parameter rv_pipe_pkg::word_t RESET_PC = '0
) (
    input  logic                    c_clk,
    input  logic                    c_rst_n,
    input  logic                    instr_valid_i,
    input  rv_isa_pkg::instr_t      instr_i,
    output logic                    instr_ready_o,
    output logic                    retire_valid_o,
    output rv_pipe_pkg::retire_t    retire_o,
    input  logic                    retire_ready_i
);

    logic                           stall;
    rv_pipe_pkg::fd_t               fd;
    rv_pipe_pkg::dx_t               dx;
    logic [rv_isa_pkg::REG_W-1:0]   rs1_idx;
    logic [rv_isa_pkg::REG_W-1:0]   rs2_idx;
    rv_pipe_pkg::word_t             rs1_val;
    rv_pipe_pkg::word_t             rs2_val;
    logic [rv_isa_pkg::REG_W-1:0]   rd_idx;
    rv_pipe_pkg::word_t             rd_val;
    logic                           rd_we;

    rv_fetch #(
        .RESET_PC       (RESET_PC       )
    ) u_fetch (
        .c_clk          (c_clk          ),
        .c_rst_n        (c_rst_n        ),
        .instr_valid_i  (instr_valid_i  ),
        .instr_i        (instr_i        ),
        .instr_ready_o  (instr_ready_o  ),
        .stall_i        (stall          ),
        .fd_o           (fd             )
    );

    rv_decode u_decode (
        .c_clk          (c_clk          ),
        .c_rst_n        (c_rst_n        ),
        .fd_i           (fd             ),
        .stall_i        (stall          ),
        .rs1_idx_o      (rs1_idx        ),
        .rs2_idx_o      (rs2_idx        ),
        .rs1_val_i      (rs1_val        ),
        .rs2_val_i      (rs2_val        ),
        .dx_o           (dx             )
    );

    rv_regfile u_regfile (
        .c_clk          (c_clk          ),
        .c_rst_n        (c_rst_n        ),
        .rs1_idx_i      (rs1_idx        ),
        .rs2_idx_i      (rs2_idx        ),
        .rs1_val_o      (rs1_val        ),
        .rs2_val_o      (rs2_val        ),
        .rd_idx_i       (rd_idx         ),
        .rd_val_i       (rd_val         ),
        .rd_we_i        (rd_we          )
    );

    rv_execute u_execute (
        .c_clk          (c_clk          ),
        .c_rst_n        (c_rst_n        ),
        .dx_i           (dx             ),
        .retire_ready_i (retire_ready_i ),
        .retire_valid_o (retire_valid_o ),
        .retire_o       (retire_o       ),
        .stall_o        (stall          ),
        .rd_idx_o       (rd_idx         ),
        .rd_val_o       (rd_val         ),
        .rd_we_o        (rd_we          )
    );

endmodule

// ==== dv/rv_core_tb.sv ====
// Testbench for the RV64I pipeline core
// random instruction stream with retire back-pressure, checked against an ISA model

`timescale 1ns/1ps

module rv_core_tb;

    localparam int                 N_INSTR  = 400;
    localparam int                 TIMEOUT  = N_INSTR * 8 + 100;
    localparam rv_pipe_pkg::word_t START_PC = 64'h1000;

    logic                 c_clk;
    logic                 c_rst_n;
    logic                 instr_valid_i;
    rv_isa_pkg::instr_t   instr_i;
    logic                 instr_ready_o;
    logic                 retire_valid_o;
    rv_pipe_pkg::retire_t retire_o;
    logic                 retire_ready_i;

    int                   seed;
    int                   cycles;
    int                   offered;
    int                   retired;
    logic                 accepted;
    logic                 held_valid;
    rv_pipe_pkg::word_t   model_regs [32];
    rv_pipe_pkg::word_t   model_pc;
    rv_pipe_pkg::retire_t exp_q [$];
    string                name_q [$];

    rv_core #(
        .RESET_PC       (START_PC       )
    ) uut (
        .c_clk          (c_clk          ),
        .c_rst_n        (c_rst_n        ),
        .instr_valid_i  (instr_valid_i  ),
        .instr_i        (instr_i        ),
        .instr_ready_o  (instr_ready_o  ),
        .retire_valid_o (retire_valid_o ),
        .retire_o       (retire_o       ),
        .retire_ready_i (retire_ready_i )
    );

    initial begin
        c_clk = 1'b0;
        forever #50 c_clk = ~c_clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge c_clk);
            cycles++;
        end
        $display("timeout: not all instructions retired within %0d cycles", TIMEOUT);
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    function automatic int rand_range(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // small register set so that dependencies are frequent
    function automatic logic [4:0] pick_reg();
        case (rand_range(6))
            0:       return 5'd0;
            1:       return 5'd1;
            2:       return 5'd2;
            3:       return 5'd3;
            4:       return 5'd7;
            default: return 5'd31;
        endcase
    endfunction

    function automatic rv_isa_pkg::instr_t make_instr();
        logic [31:0] w;
        logic [2:0]  f3;
        int          sel;
        sel = rand_range(100);
        f3  = 3'(rand_range(8));
        w   = $random(seed);
        w[11:7]  = pick_reg();
        w[19:15] = pick_reg();
        if (sel < 35) begin
            // shifts keep a legal shamt field
            if (f3 == rv_isa_pkg::F3_SLL) begin
                w[31:26] = 6'b0;
            end else if (f3 == rv_isa_pkg::F3_SR) begin
                w[31:26] = {1'b0, w[30], 4'b0};
            end
            w[14:12] = f3;
            w[6:0]   = rv_isa_pkg::OPC_OP_IMM;
        end else if (sel < 70) begin
            w[31:25] = ((f3 == rv_isa_pkg::F3_ADD || f3 == rv_isa_pkg::F3_SR) && w[30]) ?
                       7'h20 : 7'h00;
            w[24:20] = pick_reg();
            w[14:12] = f3;
            w[6:0]   = rv_isa_pkg::OPC_OP;
        end else if (sel < 83) begin
            w[6:0] = rv_isa_pkg::OPC_LUI;
        end else if (sel < 95) begin
            w[6:0] = rv_isa_pkg::OPC_AUIPC;
        end else begin
            // load, store, branch and OP-IMM-32 are outside the core
            case (rand_range(4))
                0:       w[6:0] = 7'b0000011;
                1:       w[6:0] = 7'b0100011;
                2:       w[6:0] = 7'b1100011;
                default: w[6:0] = 7'b0011011;
            endcase
        end
        return rv_isa_pkg::instr_t'(w);
    endfunction

    function automatic rv_pipe_pkg::word_t alu_model(input logic [2:0] f3, input logic sub,
            input logic arith, input rv_pipe_pkg::word_t a, input rv_pipe_pkg::word_t b);
        int sh;
        sh = int'(b[5:0]);
        case (f3)
            rv_isa_pkg::F3_ADD:  return sub ? a - b : a + b;
            rv_isa_pkg::F3_SLL:  return a << sh;
            rv_isa_pkg::F3_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            rv_isa_pkg::F3_SLTU: return (a < b) ? 64'd1 : 64'd0;
            rv_isa_pkg::F3_XOR:  return a ^ b;
            rv_isa_pkg::F3_SR:   return arith ? rv_pipe_pkg::word_t'($signed(a) >>> sh) : a >> sh;
            rv_isa_pkg::F3_OR:   return a | b;
            default:             return a & b;
        endcase
    endfunction

    task automatic model_accept(input rv_isa_pkg::instr_t ins);
        logic [31:0]          w;
        rv_pipe_pkg::word_t   a;
        rv_pipe_pkg::word_t   uimm;
        rv_pipe_pkg::retire_t exp;
        string                name;
        w    = ins;
        a    = model_regs[w[19:15]];
        uimm = {{32{w[31]}}, w[31:12], 12'b0};
        exp.pc      = model_pc;
        exp.rd      = w[11:7];
        exp.we      = 1'b1;
        exp.illegal = 1'b0;
        case (w[6:0])
            rv_isa_pkg::OPC_OP_IMM: begin
                name      = "op_imm";
                exp.value = alu_model(w[14:12], 1'b0, w[30], a, {{52{w[31]}}, w[31:20]});
            end
            rv_isa_pkg::OPC_OP: begin
                name      = "op";
                exp.value = alu_model(w[14:12], w[30], w[30], a, model_regs[w[24:20]]);
            end
            rv_isa_pkg::OPC_LUI: begin
                name      = "lui";
                exp.value = uimm;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                name      = "auipc";
                exp.value = model_pc + uimm;
            end
            default: begin
                name        = "illegal";
                exp.value   = '0;
                exp.we      = 1'b0;
                exp.illegal = 1'b1;
            end
        endcase
        if (exp.we && exp.rd != 5'd0) begin
            model_regs[exp.rd] = exp.value;
        end
        model_pc = model_pc + 64'd4;
        exp_q.push_back(exp);
        name_q.push_back(name);
    endtask

    task automatic check_retire(input string name, input rv_pipe_pkg::retire_t exp,
            input rv_pipe_pkg::retire_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // idle means no retire record and ready to take input
    task automatic check_idle(input string name);
        if ({retire_valid_o, instr_ready_o} !== 2'b01) begin
            $display("Fail %s: expected %b, actual %b", name, 2'b01,
                     {retire_valid_o, instr_ready_o});
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic drive_inputs();
        // an offered instruction stays on the port until taken
        if (!instr_valid_i || accepted) begin
            if (offered < N_INSTR && rand_range(100) < 80) begin
                instr_i       = make_instr();
                instr_valid_i = 1'b1;
                offered++;
            end else begin
                instr_i       = rv_isa_pkg::NOP;
                instr_valid_i = 1'b0;
            end
        end
        retire_ready_i = (rand_range(100) < 70);
    endtask

    // handshakes seen here complete on the next rising edge
    task automatic observe();
        rv_pipe_pkg::retire_t exp;
        string                name;
        accepted = instr_valid_i && instr_ready_o;
        if (accepted) begin
            model_accept(instr_i);
        end
        if (!retire_valid_o && held_valid) begin
            $display("retire valid dropped while the record was held");
            $display("SIMULATION FAILED");
            $fatal(1);
        end else if (retire_valid_o && exp_q.size() == 0) begin
            $display("a record was presented with no instruction outstanding");
            $display("SIMULATION FAILED");
            $fatal(1);
        end else if (retire_valid_o && retire_ready_i) begin
            exp  = exp_q.pop_front();
            name = name_q.pop_front();
            check_retire(name, exp, retire_o);
            retired++;
            held_valid = 1'b0;
        end else if (retire_valid_o) begin
            // waiting record must already match the oldest expected one
            check_retire(name_q[0], exp_q[0], retire_o);
            held_valid = 1'b1;
        end
    endtask

    initial begin
        seed           = 33837;
        offered        = 0;
        retired        = 0;
        accepted       = 1'b0;
        held_valid     = 1'b0;
        model_pc       = START_PC;
        c_rst_n        = 1'b0;
        instr_valid_i  = 1'b0;
        instr_i        = rv_isa_pkg::NOP;
        retire_ready_i = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(posedge c_clk);
        #10;
        c_rst_n = 1'b1;
        @(negedge c_clk);
        check_idle("after_reset");
        while (retired < N_INSTR) begin
            @(posedge c_clk);
            #10;
            drive_inputs();
            @(negedge c_clk);
            observe();
        end
        @(posedge c_clk);
        #10;
        instr_valid_i  = 1'b0;
        retire_ready_i = 1'b1;
        @(negedge c_clk);
        check_idle("drained");
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== rv_core.f ====
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/rv_fetch.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_core.sv
dv/rv_core_tb.sv

// ==== Makefile ====
TOP = rv_core_tb

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f rv_core.f -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only --timing -Wall --top-module rv_core -f rv_core.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
